/* Makefile */
# verilator build and run of the output layer evaluation testbench

SIM := obj_dir/Voutput_eval_tb

$(SIM): output_eval.f $(shell cat output_eval.f)
	verilator --binary --timing --assert -Wno-fatal --top-module output_eval_tb -f output_eval.f

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TESTBENCH PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* class_path.sv */
// class path, compare tree for the largest activation
// result delayed to line up with the multiplier pipeline
`timescale 1ns/1ps

module class_path #(
	parameter int MULT_STAGES = 1
)(
	input logic clk,
	input logic reset,
	input output_eval_pkg::sample_t sample_i,
	input logic start_i,
	output output_eval_pkg::class_t class_o
);

	localparam int NEURONS = output_eval_pkg::NEURONS;
	localparam int LEAVES = 1 << $clog2(NEURONS); // padded to a power of two

	// heap order: node n has children 2n and 2n+1, leaves at LEAVES..2*LEAVES-1
	output_eval_pkg::fxp_t node_val [1:2*LEAVES-1];
	logic [output_eval_pkg::IDX_W-1:0] node_idx [1:2*LEAVES-1];
	output_eval_pkg::class_t class_d;

	for (genvar g = 0; g < LEAVES; g++) begin : g_leaf
		if (g < NEURONS) begin : g_real
			assign node_val[LEAVES+g] = sample_i.act[g];
		end else begin : g_pad
			// most negative value never beats a real neuron
			assign node_val[LEAVES+g] = output_eval_pkg::FXP_MIN;
		end
		assign node_idx[LEAVES+g] = g;
	end

	// each level halves the candidates, root is node 1
	for (genvar n = LEAVES - 1; n >= 1; n--) begin : g_node
		logic take_left; // left child holds the lower indices

		assign take_left = node_val[2*n] >= node_val[2*n+1]; // ties go low
		assign node_val[n] = take_left ? node_val[2*n] : node_val[2*n+1];
		assign node_idx[n] = take_left ? node_idx[2*n] : node_idx[2*n+1];
	end

	assign class_d = '{
		valid: start_i,
		idx: node_idx[1],
		max_val: node_val[1]
	};

	pipe_delay #(
		.payload_t(output_eval_pkg::class_t),
		.DEPTH(MULT_STAGES)
	) u_class_dly (
		.clk(clk),
		.reset(reset),
		.d_i(class_d),
		.q_o(class_o)
	);

endmodule

/* cost_delta_path.sv */
// delta path, cost term a - y with a saturating add
// then one multiplier per neuron for (a - y) * adot
`timescale 1ns/1ps

module cost_delta_path #(
	parameter int MULT_STAGES = 1
)(
	input logic clk,
	input logic reset,
	input output_eval_pkg::sample_t sample_i,
	output output_eval_pkg::fxp_vec_t delta_o
);

	output_eval_pkg::fxp_vec_t cost; // cost term per neuron

	// add with clamp to the format limits
	function automatic output_eval_pkg::fxp_t sat_add(
		input output_eval_pkg::fxp_t a,
		input output_eval_pkg::fxp_t b
	);
		logic signed [output_eval_pkg::DATA_W:0] sum; // one guard bit
		sum = a + b;
		if (sum > output_eval_pkg::FXP_MAX) begin
			return output_eval_pkg::FXP_MAX;
		end else if (sum < output_eval_pkg::FXP_MIN) begin
			return output_eval_pkg::FXP_MIN;
		end
		return sum[output_eval_pkg::DATA_W-1:0];
	endfunction

	for (genvar g = 0; g < output_eval_pkg::NEURONS; g++) begin : g_neuron
		output_eval_pkg::fxp_t neg_y; // -y, either -1.0 or zero

		assign neg_y = sample_i.label[g] ? output_eval_pkg::FXP_NEG_ONE : '0;
		assign cost[g] = sat_add(sample_i.act[g], neg_y);

		fxp_mul #(
			.MULT_STAGES(MULT_STAGES)
		) u_mul (
			.clk(clk),
			.reset(reset),
			.a_i(cost[g]),
			.b_i(sample_i.deriv[g]),
			.p_o(delta_o[g]) // lands MULT_STAGES cycles later
		);
	end

endmodule

/* eval_combine.sv */
// joins deltas and prediction into one registered result
// flags a correct prediction and counts them
`timescale 1ns/1ps

module eval_combine (
	input logic clk,
	input logic reset,
	input output_eval_pkg::fxp_vec_t delta_i,
	input output_eval_pkg::class_t class_i,
	input logic [output_eval_pkg::NEURONS-1:0] label_i,
	output output_eval_pkg::result_t result_o,
	output logic result_valid_o
);

	logic hit; // label bit at the predicted neuron
	logic valid_q;
	logic [output_eval_pkg::CNT_W-1:0] count_q; // wraps at 256
	output_eval_pkg::fxp_vec_t delta_q;
	logic [output_eval_pkg::IDX_W-1:0] idx_q;
	logic correct_q;

	assign hit = label_i[class_i.idx];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= 1'b0;
			count_q <= '0;
		end else begin
			valid_q <= class_i.valid; // one cycle pulse
			if (class_i.valid && hit) begin
				count_q <= count_q + 1'b1;
			end
		end
	end

	// captured only when the class path reports done
	always_ff @(posedge clk) begin
		if (class_i.valid) begin
			delta_q <= delta_i;
			idx_q <= class_i.idx;
			correct_q <= hit;
		end
	end

	assign result_o = '{delta: delta_q, idx: idx_q, correct: correct_q, count: count_q};
	assign result_valid_o = valid_q;

endmodule

/* fxp_mul.sv */
// signed fixed point multiplier, pipelined full product
// then saturation to the 1.3.8 format and round half up
`timescale 1ns/1ps

module fxp_mul #(
	parameter int MULT_STAGES = 1
)(
	input logic clk,
	input logic reset,
	input output_eval_pkg::fxp_t a_i,
	input output_eval_pkg::fxp_t b_i,
	output output_eval_pkg::fxp_t p_o
);

	localparam int W = output_eval_pkg::DATA_W;
	localparam int IB = output_eval_pkg::INT_BITS;
	localparam int FB = output_eval_pkg::FRAC_BITS;

	output_eval_pkg::product_t prod_d; // raw product, 2 sign, 6 int, 16 frac
	output_eval_pkg::product_t prod_q; // after the pipeline
	output_eval_pkg::fxp_t trunc; // sign + kept int and frac bits
	logic [IB:0] top_bits; // bits above the kept integer part
	logic round_bit; // first dropped fraction bit
	logic ovf_pos;
	logic ovf_neg;

	assign prod_d = a_i * b_i;

	pipe_delay #(
		.payload_t(output_eval_pkg::product_t),
		.DEPTH(MULT_STAGES)
	) u_prod_dly (
		.clk(clk),
		.reset(reset),
		.d_i(prod_d),
		.q_o(prod_q)
	);

	assign top_bits = prod_q[2*W-2 -: IB+1];
	assign round_bit = prod_q[FB-1];
	assign trunc = {prod_q[2*W-1], prod_q[2*FB+IB-1:FB]};

	// positive result needs all top bits clear, negative needs all set
	assign ovf_pos = !prod_q[2*W-1] && (top_bits != '0);
	assign ovf_neg = prod_q[2*W-1] && (top_bits != '1);

	always_comb begin
		if (ovf_pos) begin
			p_o = output_eval_pkg::FXP_MAX;
		end else if (ovf_neg) begin
			p_o = output_eval_pkg::FXP_MIN;
		end else if (round_bit && (trunc != output_eval_pkg::FXP_MAX)) begin
			p_o = trunc + 1'b1; // 0.5 lsb and above goes up
		end else begin
			p_o = trunc; // max positive is never rounded past
		end
	end

endmodule

/* output_eval.f */
output_eval_pkg.sv
pipe_delay.sv
fxp_mul.sv
cost_delta_path.sv
class_path.sv
eval_combine.sv
wb_sample_port.sv
output_eval_top.sv
tb_clock_gen.sv
output_eval_assert.sv
output_eval_tb.sv

/* output_eval_assert.sv */
// wishbone protocol checks for the sample port, bound into wb_sample_port
`timescale 1ns/1ps

module output_eval_assert (
	input logic clk,
	input logic reset,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_i
);

	int unsigned err_count = 0; // failed checks so far

	a_ack_in_cycle: assert property (
		@(posedge clk) disable iff (reset) wb_ack_i |-> (wb_cyc_i && wb_stb_i)
	) else begin
		err_count++;
		$error("ack outside an active bus cycle");
	end

	// single cycle pulse per request
	a_ack_pulse: assert property (
		@(posedge clk) disable iff (reset) wb_ack_i |=> !wb_ack_i
	) else begin
		err_count++;
		$error("ack high on two cycles in a row");
	end

	a_ack_reset: assert property (@(posedge clk) reset |-> !wb_ack_i) else begin
		err_count++;
		$error("ack high during reset");
	end

endmodule

/* output_eval_pkg.sv */
// output layer evaluation types and fixed point format
// shared by the delta path, class path, combiner and bus port
package output_eval_pkg;

	// fixed point format, 1 sign + INT_BITS integer + FRAC_BITS fraction
	localparam int DATA_W = 12;
	localparam int INT_BITS = 3;
	localparam int FRAC_BITS = DATA_W - INT_BITS - 1; // 8

	localparam int NEURONS = 4; // output neurons
	localparam int IDX_W = 2; // neuron index width
	localparam int CNT_W = 8; // correct prediction counter

	typedef logic signed [DATA_W-1:0] fxp_t;
	typedef fxp_t [NEURONS-1:0] fxp_vec_t; // one value per neuron
	typedef logic signed [2*DATA_W-1:0] product_t; // full product, 2 sign bits

	// format limits
	localparam fxp_t FXP_MAX = {1'b0, {(DATA_W-1){1'b1}}};
	localparam fxp_t FXP_MIN = {1'b1, {(DATA_W-1){1'b0}}};
	// -1.0, i.e. 1 111 00000000
	localparam fxp_t FXP_NEG_ONE = {{(INT_BITS+1){1'b1}}, {FRAC_BITS{1'b0}}};

	// one sample written by the host
	typedef struct packed {
		fxp_vec_t act; // activations
		fxp_vec_t deriv; // activation derivatives
		logic [NEURONS-1:0] label; // ideal output, one bit per neuron
	} sample_t;

	// argmax result of the class path
	typedef struct packed {
		logic valid; // only marker of a finished evaluation
		logic [IDX_W-1:0] idx; // predicted neuron
		fxp_t max_val; // its activation
	} class_t;

	// combined result returned to the host
	typedef struct packed {
		fxp_vec_t delta; // (a - y) * adot per neuron
		logic [IDX_W-1:0] idx;
		logic correct; // label bit set at predicted index
		logic [CNT_W-1:0] count; // running count of correct samples
	} result_t;

endpackage

/* output_eval_tb.sv */
// directed testbench for the output layer evaluation block
// drives samples over the wishbone port and checks them against a reference model
`timescale 1ns/1ps

module output_eval_tb;

	localparam int MULT_STAGES = 2; // deeper than the default pipe
	localparam int TIMEOUT = 50; // cycles allowed per wait
	localparam int FX_MAX = (1 << (output_eval_pkg::DATA_W - 1)) - 1;
	localparam int FX_MIN = -(1 << (output_eval_pkg::DATA_W - 1));
	localparam int FX_ONE = 1 << output_eval_pkg::FRAC_BITS; // 1.0

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	output_eval_pkg::sample_t wb_dat_w;
	output_eval_pkg::result_t wb_dat_r;
	logic wb_ack;
	logic [output_eval_pkg::CNT_W-1:0] model_count; // expected running total, wraps

	tb_clock_gen u_clk (.clk_o(clk), .reset_o(reset));

	output_eval_top #(.MULT_STAGES(MULT_STAGES)) DUT (
		.clk(clk),
		.reset(reset),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_we_i(wb_we),
		.wb_dat_i(wb_dat_w),
		.wb_dat_o(wb_dat_r),
		.wb_ack_o(wb_ack)
	);

	bind wb_sample_port output_eval_assert u_wb_assert (
		.clk(clk),
		.reset(reset),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_ack_i(wb_ack_o)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic output_eval_pkg::fxp_t fx(input int v);
		return output_eval_pkg::fxp_t'(v); // raw lsb count into the 1.3.8 format
	endfunction

	function automatic int clamp(input int v);
		return (v > FX_MAX) ? FX_MAX : ((v < FX_MIN) ? FX_MIN : v);
	endfunction

	// (a - y) * adot, saturated, rounded half up on the dropped fraction
	function automatic output_eval_pkg::fxp_t model_delta(input output_eval_pkg::fxp_t act,
			input output_eval_pkg::fxp_t deriv, input logic label);
		int cost;
		int prod;
		cost = clamp(int'(act) - (label ? FX_ONE : 0));
		prod = cost * int'(deriv);
		return fx(clamp((prod + FX_ONE / 2) >>> output_eval_pkg::FRAC_BITS));
	endfunction

	function automatic output_eval_pkg::sample_t pack(input int a0, a1, a2, a3,
			input int d0, d1, d2, d3, input logic [3:0] label);
		output_eval_pkg::sample_t s;
		s.act = {fx(a3), fx(a2), fx(a1), fx(a0)}; // neuron 0 in the low slot
		s.deriv = {fx(d3), fx(d2), fx(d1), fx(d0)};
		s.label = label;
		return s;
	endfunction

	// expected result, also advances the model count
	task automatic predict(input output_eval_pkg::sample_t s,
			output output_eval_pkg::result_t want);
		int best;
		best = 0;
		for (int i = 0; i < output_eval_pkg::NEURONS; i++) begin
			want.delta[i] = model_delta(s.act[i], s.deriv[i], s.label[i]);
			if (s.act[i] > s.act[best]) begin
				best = i; // strict compare, ties stay with the lower index
			end
		end
		want.idx = best[output_eval_pkg::IDX_W-1:0];
		want.correct = s.label[best];
		if (want.correct) begin
			model_count++;
		end
		want.count = model_count;
	endtask

	task automatic bus_idle();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// called on a falling edge, returns on one
	task automatic bus_write(input output_eval_pkg::sample_t s, output int waited);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_dat_w = s;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT) begin
				abort_run("write to the sample port was never acknowledged");
			end
		end while (!wb_ack);
		@(negedge clk); // strobe held over the edge that takes the ack
		bus_idle();
	endtask

	task automatic bus_read(output output_eval_pkg::result_t got);
		int n;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) begin
				abort_run("read from the sample port was never acknowledged");
			end
		end while (!wb_ack);
		got = wb_dat_r; // held result, stable mid cycle
		@(negedge clk);
		bus_idle();
	endtask

	task automatic check_deltas(input output_eval_pkg::fxp_vec_t got,
			input output_eval_pkg::fxp_vec_t want, input string what);
		for (int i = 0; i < output_eval_pkg::NEURONS; i++) begin
			if (got[i] !== want[i]) begin
				abort_run($sformatf("FAIL %0t: %s delta[%0d] got %0d expected %0d",
					$time, what, i, got[i], want[i]));
			end
		end
	endtask

	task automatic check_result(input output_eval_pkg::result_t got,
			input output_eval_pkg::result_t want, input string what);
		if (got.idx !== want.idx) begin
			abort_run($sformatf("FAIL %0t: %s index got %0d expected %0d",
				$time, what, got.idx, want.idx));
		end
		if (got.correct !== want.correct) begin
			abort_run($sformatf("FAIL %0t: %s correct flag got %b expected %b",
				$time, what, got.correct, want.correct));
		end
		if (got.count !== want.count) begin
			abort_run($sformatf("FAIL %0t: %s count got %0d expected %0d",
				$time, what, got.count, want.count));
		end
	endtask

	task automatic run_sample(input output_eval_pkg::sample_t s, input string what);
		output_eval_pkg::result_t want;
		output_eval_pkg::result_t got;
		int waited;
		bus_write(s, waited);
		predict(s, want);
		bus_read(got); // waits out the evaluation
		check_deltas(got.delta, want.delta, what);
		check_result(got, want, what);
	endtask

	task automatic test_reset_state();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (wb_ack) begin
				abort_run("ack was raised while reset was active");
			end
			if (n > TIMEOUT) begin
				abort_run("reset was never released");
			end
		end while (reset !== 1'b0);
		// nothing held yet, a read must stall
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		repeat (TIMEOUT) begin
			@(negedge clk);
			if (wb_ack) begin
				abort_run("read was acknowledged before any sample was written");
			end
		end
		bus_idle();
	endtask

	task automatic test_delta_math();
		// cost clamp at -8.0, half lsb rounding, negative product saturation
		run_sample(pack(256, -2048, 1, 2047, 512, 256, 128, -2048, 4'b0011), "delta set 1");
		// positive saturation, -0.5 lsb rounds to zero, 1.5 lsb rounds to 2
		run_sample(pack(-2048, -1, 3, 100, -2048, 128, 128, 300, 4'b0001), "delta set 2");
		run_sample(pack(2047, 300, -300, 0, 2047, -400, -400, 2047, 4'b0000), "delta set 3");
	endtask

	task automatic test_argmax();
		run_sample(pack(128, -256, 768, 256, 256, 256, 256, 256, 4'b0100), "distinct max");
		run_sample(pack(-256, 512, 0, 512, 64, 64, 64, 64, 4'b1000), "tie low index");
		run_sample(pack(-768, -128, -512, -128, 32, 32, 32, 32, 4'b0010), "negative tie");
		run_sample(pack(-2048, -2048, -2048, -2048, 1, 1, 1, 1, 4'b0001), "all minimum");
	endtask

	task automatic test_correct_count();
		logic [127:0] r;
		for (int i = 0; i < 40; i++) begin
			r = {$urandom, $urandom, $urandom, $urandom};
			run_sample(r[99:0], $sformatf("random sample %0d", i));
		end
	endtask

	task automatic test_back_pressure();
		output_eval_pkg::sample_t s_first;
		output_eval_pkg::sample_t s_second;
		output_eval_pkg::result_t want;
		output_eval_pkg::result_t got;
		int waited;
		s_first = pack(640, 0, 0, 0, 256, 256, 256, 256, 4'b0001); // correct, bumps count
		s_second = pack(0, 0, 0, 900, -300, 200, 100, 400, 4'b1001);
		bus_write(s_first, waited);
		predict(s_first, want);
		bus_write(s_second, waited); // issued right after the first ack
		if (waited <= MULT_STAGES + 1) begin
			abort_run($sformatf("FAIL %0t: second write acked after %0d cycles while busy",
				$time, waited));
		end
		predict(s_second, want);
		bus_read(got);
		check_deltas(got.delta, want.delta, "back-pressure");
		check_result(got, want, "back-pressure");
	endtask

	initial begin
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_dat_w = '0;
		model_count = '0;
		void'($urandom(26708));
		test_reset_state();
		test_delta_math();
		test_argmax();
		test_correct_count();
		test_back_pressure();
		if (DUT.u_port.u_wb_assert.err_count != 0) begin
			abort_run("bus protocol assertions failed during the run");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

/* output_eval_top.sv */
// output layer evaluation top
// bus port feeding the delta and class paths and the combiner
`timescale 1ns/1ps

module output_eval_top #(
	parameter int MULT_STAGES = 1 // multiplier pipeline depth
)(
	input logic clk,
	input logic reset,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input output_eval_pkg::sample_t wb_dat_i,
	output output_eval_pkg::result_t wb_dat_o,
	output logic wb_ack_o
);

	output_eval_pkg::sample_t sample; // held sample, both paths
	logic start;
	output_eval_pkg::fxp_vec_t delta;
	output_eval_pkg::class_t cls;
	output_eval_pkg::result_t result;
	logic result_valid;

	wb_sample_port u_port (
		.clk(clk),
		.reset(reset),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.sample_o(sample),
		.start_o(start),
		.result_i(result),
		.result_valid_i(result_valid)
	);

	cost_delta_path #(.MULT_STAGES(MULT_STAGES)) u_delta (
		.clk(clk),
		.reset(reset),
		.sample_i(sample),
		.delta_o(delta)
	);

	class_path #(.MULT_STAGES(MULT_STAGES)) u_class (
		.clk(clk),
		.reset(reset),
		.sample_i(sample),
		.start_i(start),
		.class_o(cls)
	);

	eval_combine u_combine (
		.clk(clk),
		.reset(reset),
		.delta_i(delta),
		.class_i(cls),
		.label_i(sample.label),
		.result_o(result),
		.result_valid_o(result_valid)
	);

endmodule

/* pipe_delay.sv */
// typed delay line
// shifts any packed payload through DEPTH registers
`timescale 1ns/1ps

module pipe_delay #(
	parameter type payload_t = logic,
	parameter int DEPTH = 1 // 1 or more
)(
	input logic clk,
	input logic reset,
	input payload_t d_i,
	output payload_t q_o
);

	payload_t stage_q [DEPTH]; // stage 0 takes d_i

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= d_i;
			// every later stage takes the one before it
			for (int i = 1; i < DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign q_o = stage_q[DEPTH-1]; // oldest entry

endmodule

/* tb_clock_gen.sv */
// testbench clock, 40 ns period, and power-on reset
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD = 20,
	parameter int RESET_CYCLES = 10
)(
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#HALF_PERIOD clk_o = ~clk_o;
		end
	end

	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b0; // flops on this edge still see reset high
	end

endmodule

/* wb_sample_port.sv */
// wishbone classic slave, takes a sample and starts the evaluation
// holds the last result for reads, stalls writes while busy
`timescale 1ns/1ps

module wb_sample_port (
	input logic clk,
	input logic reset,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input output_eval_pkg::sample_t wb_dat_i,
	output output_eval_pkg::result_t wb_dat_o,
	output logic wb_ack_o,
	output output_eval_pkg::sample_t sample_o,
	output logic start_o,
	input output_eval_pkg::result_t result_i,
	input logic result_valid_i
);

	logic req; // live request not yet acked
	logic wr_ok; // write can be taken now
	logic rd_ok; // read can be served now
	logic ack_q;
	logic start_q;
	logic pending_q; // evaluation in flight
	logic held_q; // a result is available
	output_eval_pkg::sample_t sample_q;
	output_eval_pkg::result_t result_q;

	// ack_q blocks a second ack on the cycle the first one is out
	assign req = wb_cyc_i && wb_stb_i && !ack_q;
	assign wr_ok = req && wb_we_i && !pending_q; // back-pressure
	assign rd_ok = req && !wb_we_i && held_q && !pending_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack_q <= 1'b0;
			start_q <= 1'b0;
			pending_q <= 1'b0;
			held_q <= 1'b0;
		end else begin
			ack_q <= wr_ok || rd_ok;
			// start follows the write ack by one cycle
			start_q <= ack_q && wb_cyc_i && wb_stb_i && wb_we_i;
			if (wr_ok) begin
				pending_q <= 1'b1;
			end else if (result_valid_i) begin
				pending_q <= 1'b0;
			end
			if (result_valid_i) begin
				held_q <= 1'b1; // stays set, results are re-readable
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			sample_q <= wb_dat_i; // stable until the result is captured
		end
		if (result_valid_i) begin
			result_q <= result_i;
		end
	end

	assign wb_ack_o = ack_q;
	assign wb_dat_o = result_q;
	assign sample_o = sample_q;
	assign start_o = start_q;

endmodule
